// File: src/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    typedef enum logic [4:0] {
        SLT_OP         = 5'b00011,
        SHIFT_CALC     = 5'b00100,
        WRITE_BACK_SH  = 5'b00101,
        ALU_OP_R       = 5'b00110,
        WRITE_BACK_R   = 5'b00111,
        JUMP_REG       = 5'b01000,
        JUMP           = 5'b01011,
        ALU_OP_IMM     = 5'b01101,
        WRITE_BACK_IMM = 5'b01110,
        BRANCH_OP      = 5'b01111,
        ADDR_CALC      = 5'b10000,
        MEM_READ       = 5'b10001,
        WRITE_BACK_LUI = 5'b10011,
        WRITE_BACK_LW  = 5'b10100,
        MEM_WRITE_W    = 5'b10101,
        WRITE_BACK_LB  = 5'b10110,
        MEM_READ_SB    = 5'b10111,
        MEM_WRITE_B    = 5'b11000,
        FETCH          = 5'b11001,
        BRANCH_END     = 5'b11010,
        DECODE         = 5'b11011,
        RESET          = 5'b11100
    } state_t;

    typedef enum logic [3:0] {
        CLS_NONE, CLS_R_ALU, CLS_SHIFT, CLS_SLT, CLS_JR, CLS_J, CLS_ADDI,
        CLS_BRANCH, CLS_LUI, CLS_LW, CLS_LB, CLS_SW, CLS_SB
    } instr_class_t;

    localparam logic [5:0] OP_RTYPE = 6'b000000;
    localparam logic [5:0] OP_J     = 6'b000010;
    localparam logic [5:0] OP_BEQ   = 6'b000100;
    localparam logic [5:0] OP_BNE   = 6'b000101;
    localparam logic [5:0] OP_ADDI  = 6'b001000;
    localparam logic [5:0] OP_LUI   = 6'b001111;
    localparam logic [5:0] OP_LB    = 6'b100000;
    localparam logic [5:0] OP_LW    = 6'b100011;
    localparam logic [5:0] OP_SB    = 6'b101000;
    localparam logic [5:0] OP_SW    = 6'b101011;

    localparam logic [5:0] FN_SLL = 6'b000000;
    localparam logic [5:0] FN_SRA = 6'b000011;
    localparam logic [5:0] FN_JR  = 6'b001000;
    localparam logic [5:0] FN_ADD = 6'b100000;
    localparam logic [5:0] FN_SUB = 6'b100010;
    localparam logic [5:0] FN_AND = 6'b100100;
    localparam logic [5:0] FN_SLT = 6'b101010;

    localparam logic [2:0] ALU_PASS = 3'd0;
    localparam logic [2:0] ALU_ADD  = 3'd1;
    localparam logic [2:0] ALU_SUB  = 3'd2;
    localparam logic [2:0] ALU_AND  = 3'd3;

    localparam logic [2:0] SH_NONE = 3'd0;
    localparam logic [2:0] SH_SLL  = 3'd2;
    localparam logic [2:0] SH_SRA  = 3'd4;

    localparam logic [1:0] IOD_PC      = 2'd0;
    localparam logic [1:0] IOD_ALU_OUT = 2'd3;

    localparam logic [2:0] WB_SHIFT    = 3'd0;
    localparam logic [2:0] WB_MEM_WORD = 3'd2;
    localparam logic [2:0] WB_LT       = 3'd3;
    localparam logic [2:0] WB_MEM_BYTE = 3'd4;
    localparam logic [2:0] WB_ALU_OUT  = 3'd5;
    localparam logic [2:0] WB_LUI      = 3'd6;

    localparam logic [1:0] PC_ALU     = 2'd0;
    localparam logic [1:0] PC_ALU_OUT = 2'd1; // branch target held from BRANCH_END
    localparam logic [1:0] PC_JUMP    = 2'd2;
    localparam logic [1:0] PC_REG_A   = 2'd3;

    localparam logic [1:0] SRC_A_PC  = 2'd0;
    localparam logic [1:0] SRC_A_REG = 2'd1;

    localparam logic [1:0] SRC_B_REG     = 2'd0;
    localparam logic [1:0] SRC_B_FOUR    = 2'd1;
    localparam logic [1:0] SRC_B_IMM     = 2'd2;
    localparam logic [1:0] SRC_B_IMM_SH2 = 2'd3;

    localparam logic [1:0] DST_RT = 2'd0;
    localparam logic [1:0] DST_RD = 2'd1;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_word_t;

endpackage

`default_nettype wire

// File: src/instr_decoder.sv
`default_nettype none

module instr_decoder (
    input  ctrl_pkg::instr_word_t  i_instr,
    output ctrl_pkg::instr_class_t o_class,
    output logic [2:0]             o_alu_op,
    output logic [2:0]             o_sh_op
);
    import ctrl_pkg::*;

    always_comb begin
        o_class  = CLS_NONE;
        o_alu_op = ALU_PASS;
        o_sh_op  = SH_NONE;
        case (i_instr.r.opcode)
            OP_RTYPE: begin
                case (i_instr.r.funct)
                    FN_ADD: begin
                        o_class  = CLS_R_ALU;
                        o_alu_op = ALU_ADD;
                    end
                    FN_SUB: begin
                        o_class  = CLS_R_ALU;
                        o_alu_op = ALU_SUB;
                    end
                    FN_AND: begin
                        o_class  = CLS_R_ALU;
                        o_alu_op = ALU_AND;
                    end
                    FN_SLL: begin
                        o_class = CLS_SHIFT;
                        o_sh_op = SH_SLL;
                    end
                    FN_SRA: begin
                        o_class = CLS_SHIFT;
                        o_sh_op = SH_SRA;
                    end
                    FN_SLT: begin
                        o_class  = CLS_SLT;
                        o_alu_op = ALU_SUB; // sign of a - b
                    end
                    FN_JR: o_class = CLS_JR;
                    default: o_class = CLS_NONE;
                endcase
            end
            OP_J:    o_class = CLS_J;
            OP_ADDI: o_class = CLS_ADDI;
            OP_BEQ, OP_BNE: begin
                o_class  = CLS_BRANCH;
                o_alu_op = ALU_SUB; // compare for eq
            end
            OP_LUI:  o_class = CLS_LUI;
            OP_LW:   o_class = CLS_LW;
            OP_LB:   o_class = CLS_LB;
            OP_SW:   o_class = CLS_SW;
            OP_SB:   o_class = CLS_SB;
            default: o_class = CLS_NONE;
        endcase
    end

endmodule

`default_nettype wire

// File: src/ctrl_sequencer.sv
`default_nettype none

module ctrl_sequencer (
    input  logic                   clk,
    input  logic                   reset,
    input  ctrl_pkg::instr_class_t i_class,
    output ctrl_pkg::state_t       o_state
);
    import ctrl_pkg::*;

    state_t       state_q;
    state_t       state_d;
    instr_class_t class_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= RESET;
            class_q <= CLS_NONE;
        end else begin
            state_q <= state_d;
            if (state_q == DECODE) begin
                class_q <= i_class; // needed again after ADDR_CALC
            end
        end
    end

    always_comb begin
        state_d = FETCH;
        case (state_q)
            RESET:      state_d = FETCH;
            FETCH:      state_d = BRANCH_END;
            BRANCH_END: state_d = DECODE;
            DECODE: begin
                case (i_class)
                    CLS_R_ALU:  state_d = ALU_OP_R;
                    CLS_SHIFT:  state_d = SHIFT_CALC;
                    CLS_SLT:    state_d = SLT_OP;
                    CLS_JR:     state_d = JUMP_REG;
                    CLS_J:      state_d = JUMP;
                    CLS_ADDI:   state_d = ALU_OP_IMM;
                    CLS_BRANCH: state_d = BRANCH_OP;
                    CLS_LUI:    state_d = WRITE_BACK_LUI;
                    CLS_LW, CLS_LB, CLS_SW, CLS_SB: begin
                        state_d = ADDR_CALC;
                    end
                    default:    state_d = FETCH; // undefined code, skip it
                endcase
            end
            ALU_OP_R:   state_d = WRITE_BACK_R;
            SHIFT_CALC: state_d = WRITE_BACK_SH;
            ALU_OP_IMM: state_d = WRITE_BACK_IMM;
            ADDR_CALC: begin
                case (class_q)
                    CLS_LW, CLS_LB: state_d = MEM_READ;
                    CLS_SW:         state_d = MEM_WRITE_W;
                    CLS_SB:         state_d = MEM_READ_SB; // read-modify-write
                    default:        state_d = FETCH;
                endcase
            end
            MEM_READ: begin
                if (class_q == CLS_LB) begin
                    state_d = WRITE_BACK_LB;
                end else begin
                    state_d = WRITE_BACK_LW;
                end
            end
            MEM_READ_SB: state_d = MEM_WRITE_B;
            // terminal states
            WRITE_BACK_R,
            WRITE_BACK_SH,
            WRITE_BACK_IMM,
            WRITE_BACK_LUI,
            WRITE_BACK_LW,
            WRITE_BACK_LB,
            SLT_OP,
            JUMP_REG,
            JUMP,
            BRANCH_OP,
            MEM_WRITE_W,
            MEM_WRITE_B: state_d = FETCH;
            default:     state_d = FETCH;
        endcase
    end

    assign o_state = state_q;

endmodule

`default_nettype wire

// File: src/ctrl_word_gen.sv
`default_nettype none

module ctrl_word_gen (
    input  logic             clk,
    input  logic             reset,
    input  ctrl_pkg::state_t i_state,
    input  logic [2:0]       i_alu_op,
    input  logic [2:0]       i_sh_op,
    input  logic             i_opcode_lsb,
    input  logic             i_eq,
    output logic             o_pc_write,
    output logic             o_mem_read,
    output logic             o_mem_write,
    output logic             o_byte_or_word,
    output logic             o_ir_write,
    output logic             o_reg_write,
    output logic [1:0]       o_i_or_d,
    output logic [2:0]       o_mem_to_reg,
    output logic [1:0]       o_pc_src,
    output logic [2:0]       o_alu_op,
    output logic [1:0]       o_alu_src_a,
    output logic [1:0]       o_alu_src_b,
    output logic [1:0]       o_reg_dst,
    output logic [2:0]       o_sh_op
);
    import ctrl_pkg::*;

    logic [2:0] alu_op_q;
    logic [2:0] sh_op_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_op_q <= ALU_PASS;
            sh_op_q  <= SH_NONE;
        end else if (i_state == DECODE) begin
            alu_op_q <= i_alu_op;
            sh_op_q  <= i_sh_op;
        end
    end

    always_comb begin
        o_pc_write     = 1'b0;
        o_mem_read     = 1'b0;
        o_mem_write    = 1'b0;
        o_byte_or_word = 1'b0;
        o_ir_write     = 1'b0;
        o_reg_write    = 1'b0;
        o_i_or_d       = IOD_PC;
        o_mem_to_reg   = WB_SHIFT;
        o_pc_src       = PC_ALU;
        o_alu_op       = ALU_PASS;
        o_alu_src_a    = SRC_A_PC;
        o_alu_src_b    = SRC_B_REG;
        o_reg_dst      = DST_RT;
        o_sh_op        = SH_NONE;
        case (i_state)
            FETCH: begin
                o_pc_write  = 1'b1; // pc + 4
                o_mem_read  = 1'b1;
                o_ir_write  = 1'b1;
                o_alu_op    = ALU_ADD;
                o_alu_src_b = SRC_B_FOUR;
            end
            BRANCH_END: begin
                o_alu_op    = ALU_ADD;
                o_alu_src_b = SRC_B_IMM_SH2;
            end
            ALU_OP_R: begin
                o_alu_op    = alu_op_q;
                o_alu_src_a = SRC_A_REG;
            end
            BRANCH_OP: begin
                o_alu_op    = alu_op_q;
                o_alu_src_a = SRC_A_REG;
                o_pc_write  = i_eq ^ i_opcode_lsb; // beq on eq, bne on !eq
                o_pc_src    = PC_ALU_OUT;
            end
            SLT_OP: begin
                o_alu_op     = alu_op_q;
                o_alu_src_a  = SRC_A_REG;
                o_reg_write  = 1'b1;
                o_mem_to_reg = WB_LT;
                o_reg_dst    = DST_RD;
            end
            SHIFT_CALC: o_sh_op = sh_op_q;
            WRITE_BACK_SH: begin
                o_reg_write  = 1'b1;
                o_mem_to_reg = WB_SHIFT;
                o_reg_dst    = DST_RD;
            end
            WRITE_BACK_R: begin
                o_reg_write  = 1'b1;
                o_mem_to_reg = WB_ALU_OUT;
                o_reg_dst    = DST_RD;
            end
            ALU_OP_IMM, ADDR_CALC: begin
                o_alu_op    = ALU_ADD;
                o_alu_src_a = SRC_A_REG;
                o_alu_src_b = SRC_B_IMM;
            end
            WRITE_BACK_IMM: begin
                o_reg_write  = 1'b1;
                o_mem_to_reg = WB_ALU_OUT;
            end
            WRITE_BACK_LUI: begin
                o_reg_write  = 1'b1;
                o_mem_to_reg = WB_LUI;
            end
            MEM_READ: begin
                o_mem_read = 1'b1;
                o_i_or_d   = IOD_ALU_OUT;
            end
            MEM_READ_SB: begin
                o_mem_read  = 1'b1;
                o_i_or_d    = IOD_ALU_OUT;
                o_alu_op    = ALU_ADD; // keep the address in alu out
                o_alu_src_a = SRC_A_REG;
                o_alu_src_b = SRC_B_IMM;
            end
            WRITE_BACK_LW: begin
                o_reg_write  = 1'b1;
                o_mem_to_reg = WB_MEM_WORD;
            end
            WRITE_BACK_LB: begin
                o_reg_write  = 1'b1;
                o_mem_to_reg = WB_MEM_BYTE;
            end
            MEM_WRITE_W: begin
                o_mem_write = 1'b1;
                o_i_or_d    = IOD_ALU_OUT;
            end
            MEM_WRITE_B: begin
                o_mem_write    = 1'b1;
                o_byte_or_word = 1'b1;
                o_i_or_d       = IOD_ALU_OUT;
            end
            JUMP: begin
                o_pc_write = 1'b1;
                o_pc_src   = PC_JUMP;
            end
            JUMP_REG: begin
                o_pc_write = 1'b1;
                o_pc_src   = PC_REG_A;
            end
            default: ; // RESET, DECODE drive nothing
        endcase
    end

endmodule

`default_nettype wire

// File: src/mips_ctrl_unit.sv
`default_nettype none

module mips_ctrl_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  ctrl_pkg::instr_word_t i_instr,
    input  logic                  i_eq,
    output logic                  o_pc_write,
    output logic                  o_mem_read,
    output logic                  o_mem_write,
    output logic                  o_byte_or_word,
    output logic                  o_ir_write,
    output logic                  o_reg_write,
    output logic [1:0]            o_i_or_d,
    output logic [2:0]            o_mem_to_reg,
    output logic [1:0]            o_pc_src,
    output logic [2:0]            o_alu_op,
    output logic [1:0]            o_alu_src_a,
    output logic [1:0]            o_alu_src_b,
    output logic [1:0]            o_reg_dst,
    output logic [2:0]            o_sh_op
);
    import ctrl_pkg::*;

    instr_class_t dec_class;
    logic [2:0]   dec_alu_op;
    logic [2:0]   dec_sh_op;
    state_t       state;

    instr_decoder u_instr_decoder (
        .i_instr  (i_instr),
        .o_class  (dec_class),
        .o_alu_op (dec_alu_op),
        .o_sh_op  (dec_sh_op)
    );

    ctrl_sequencer u_ctrl_sequencer (
        .clk     (clk),
        .reset   (reset),
        .i_class (dec_class),
        .o_state (state)
    );

    ctrl_word_gen u_ctrl_word_gen (
        .clk            (clk),
        .reset          (reset),
        .i_state        (state),
        .i_alu_op       (dec_alu_op),
        .i_sh_op        (dec_sh_op),
        .i_opcode_lsb   (i_instr.r.opcode[0]), // instr bit 26, beq vs bne
        .i_eq           (i_eq),
        .o_pc_write     (o_pc_write),
        .o_mem_read     (o_mem_read),
        .o_mem_write    (o_mem_write),
        .o_byte_or_word (o_byte_or_word),
        .o_ir_write     (o_ir_write),
        .o_reg_write    (o_reg_write),
        .o_i_or_d       (o_i_or_d),
        .o_mem_to_reg   (o_mem_to_reg),
        .o_pc_src       (o_pc_src),
        .o_alu_op       (o_alu_op),
        .o_alu_src_a    (o_alu_src_a),
        .o_alu_src_b    (o_alu_src_b),
        .o_reg_dst      (o_reg_dst),
        .o_sh_op        (o_sh_op)
    );

endmodule

`default_nettype wire

// File: bench/ctrl_checker.sv
`default_nettype none

module ctrl_checker (
    input  logic        clk,
    input  logic        reset,
    input  logic        i_active,
    input  logic [31:0] i_test_id,
    input  logic [3:0]  i_exp_cycles,
    input  logic [1:0]  i_exp_rw,
    input  logic [2:0]  i_exp_m2r,
    input  logic [1:0]  i_exp_dst,
    input  logic [1:0]  i_exp_mw,
    input  logic        i_exp_bow,
    input  logic [1:0]  i_exp_mr,
    input  logic [1:0]  i_exp_pcw,
    input  logic [1:0]  i_exp_pcsrc,
    input  logic [2:0]  i_exp_alu4,
    input  logic [2:0]  i_exp_sh4,
    input  logic        i_pc_write,
    input  logic        i_mem_read,
    input  logic        i_mem_write,
    input  logic        i_byte_or_word,
    input  logic        i_ir_write,
    input  logic        i_reg_write,
    input  logic [1:0]  i_i_or_d,
    input  logic [2:0]  i_mem_to_reg,
    input  logic [1:0]  i_pc_src,
    input  logic [2:0]  i_alu_op,
    input  logic [1:0]  i_alu_src_a,
    input  logic [1:0]  i_alu_src_b,
    input  logic [1:0]  i_reg_dst,
    input  logic [2:0]  i_sh_op,
    output int          o_tests,
    output int          o_errors
);
    import ctrl_pkg::*;

    int         cycles;
    int         rel_cnt;
    int         rw_cnt, mw_cnt, mr_cnt, pcw_cnt;
    int         err_before;
    logic       reset_d = 1'b0;
    logic       seen_first;
    logic [2:0] m2r, alu4, sh4;
    logic [1:0] dst, pcsrc, srca4;
    logic       bow;

    initial begin
        o_tests  = 0;
        o_errors = 0;
    end

    task automatic check_val(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] t=%0t %s got %0d exp %0d", $time, name, got, exp);
            o_errors++;
        end
    endtask

    task automatic check_idle();
        check_val("pc_write", i_pc_write, 0);
        check_val("mem_read", i_mem_read, 0);
        check_val("mem_write", i_mem_write, 0);
        check_val("byte_or_word", i_byte_or_word, 0);
        check_val("ir_write", i_ir_write, 0);
        check_val("reg_write", i_reg_write, 0);
        check_val("i_or_d", i_i_or_d, 0);
        check_val("mem_to_reg", i_mem_to_reg, 0);
        check_val("pc_src", i_pc_src, 0);
        check_val("alu_op", i_alu_op, 0);
        check_val("alu_src_a", i_alu_src_a, 0);
        check_val("alu_src_b", i_alu_src_b, 0);
        check_val("reg_dst", i_reg_dst, 0);
        check_val("sh_op", i_sh_op, 0);
    endtask

    task automatic check_fetch_word();
        check_val("fetch pc_write", i_pc_write, 1);
        check_val("fetch mem_read", i_mem_read, 1);
        check_val("fetch alu_op", i_alu_op, ALU_ADD);
        check_val("fetch alu_src_a", i_alu_src_a, SRC_A_PC);
        check_val("fetch alu_src_b", i_alu_src_b, SRC_B_FOUR);
        check_val("fetch i_or_d", i_i_or_d, IOD_PC);
    endtask

    task automatic finish_test();
        err_before = o_errors;
        check_fetch_word();
        check_val("cycles", cycles, i_exp_cycles);
        check_val("reg_write count", rw_cnt, i_exp_rw);
        check_val("mem_to_reg", m2r, i_exp_m2r);
        check_val("reg_dst", dst, i_exp_dst);
        check_val("mem_write count", mw_cnt, i_exp_mw);
        check_val("byte_or_word", bow, i_exp_bow);
        check_val("mem_read count", mr_cnt, i_exp_mr);
        check_val("pc_write count", pcw_cnt, i_exp_pcw);
        check_val("pc_src", pcsrc, i_exp_pcsrc);
        if (i_exp_alu4 != 3'd7) begin // 7 marks no fourth cycle
            check_val("alu_op", alu4, i_exp_alu4);
            check_val("sh_op", sh4, i_exp_sh4);
            // an alu operation in cycle 4 works on register a
            check_val("alu_src_a", srca4,
                      (i_exp_alu4 == ALU_PASS) ? SRC_A_PC : SRC_A_REG);
        end
        o_tests++;
        $display("test %0d: %0d cycles, %s", i_test_id, cycles,
                 (o_errors == err_before) ? "ok" : "mismatch");
    endtask

    always @(posedge clk) begin
        if (reset) begin
            rel_cnt    = 0;
            seen_first = 1'b0;
            if (reset_d) check_idle();
        end else begin
            if (reset_d) check_idle(); // state RESET after release
            rel_cnt++;
            if (i_ir_write) begin
                if (!seen_first) begin
                    seen_first = 1'b1;
                    if (rel_cnt != 2) begin
                        $display("first fetch came %0d cycles after reset, not 2", rel_cnt);
                        o_errors++;
                    end
                end
                if (i_active) begin
                    finish_test();
                end else begin
                    check_fetch_word();
                end
                cycles  = 1;
                rw_cnt  = 0;
                mw_cnt  = 0;
                mr_cnt  = 0;
                pcw_cnt = 0;
                m2r     = 3'd0;
                dst     = 2'd0;
                pcsrc   = 2'd0;
                bow     = 1'b0;
                alu4    = 3'd0;
                sh4     = 3'd0;
                srca4   = 2'd0;
            end else begin
                cycles++;
                if (cycles == 2) begin
                    check_val("alu_src_b", i_alu_src_b, SRC_B_IMM_SH2); // branch target
                end
                if (cycles == 4) begin
                    alu4  = i_alu_op;
                    sh4   = i_sh_op;
                    srca4 = i_alu_src_a;
                end
                if (i_mem_read || i_mem_write) begin
                    check_val("i_or_d", i_i_or_d, IOD_ALU_OUT);
                end
                if (i_reg_write) begin
                    rw_cnt++;
                    m2r = i_mem_to_reg;
                    dst = i_reg_dst;
                end
                if (i_mem_write) begin
                    mw_cnt++;
                    bow = i_byte_or_word;
                end
                if (i_mem_read) mr_cnt++;
                if (i_pc_write) begin
                    pcw_cnt++;
                    pcsrc = i_pc_src;
                end
            end
        end
        reset_d <= reset;
    end

endmodule

`default_nettype wire

// File: bench/tb_mips_ctrl_unit.sv
`default_nettype none

module tb_mips_ctrl_unit;
    import ctrl_pkg::*;

    typedef struct {
        logic [5:0] op;
        logic [5:0] fn;
        logic       br;
        logic [3:0] cycles;
        logic [1:0] rw;
        logic [2:0] m2r;
        logic [1:0] dst;
        logic [1:0] mw;
        logic       bow;
        logic [1:0] mr;
        logic [1:0] pcw;
        logic [1:0] pcsrc;
        logic [2:0] alu4;
        logic [2:0] sh4;
    } row_t;

    row_t        table_q[$];
    logic        clk;
    logic        reset;
    instr_word_t instr;
    logic        eq;
    logic        active;
    logic [31:0] test_id;
    logic [31:0] rnd;
    row_t        exp_row;
    logic [1:0]  exp_pcw;
    logic [1:0]  exp_pcsrc;
    int          tests;
    int          errors;
    int          expected_tests;
    logic        ok;

    logic pc_write, mem_read, mem_write, byte_or_word, ir_write, reg_write;
    logic [1:0] i_or_d, pc_src, alu_src_a, alu_src_b, reg_dst;
    logic [2:0] mem_to_reg, alu_op, sh_op;

    mips_ctrl_unit i_mips_ctrl_unit (
        .clk(clk), .reset(reset), .i_instr(instr), .i_eq(eq),
        .o_pc_write(pc_write), .o_mem_read(mem_read), .o_mem_write(mem_write),
        .o_byte_or_word(byte_or_word), .o_ir_write(ir_write), .o_reg_write(reg_write),
        .o_i_or_d(i_or_d), .o_mem_to_reg(mem_to_reg), .o_pc_src(pc_src),
        .o_alu_op(alu_op), .o_alu_src_a(alu_src_a), .o_alu_src_b(alu_src_b),
        .o_reg_dst(reg_dst), .o_sh_op(sh_op)
    );

    ctrl_checker i_checker (
        .clk(clk), .reset(reset), .i_active(active), .i_test_id(test_id),
        .i_exp_cycles(exp_row.cycles), .i_exp_rw(exp_row.rw), .i_exp_m2r(exp_row.m2r),
        .i_exp_dst(exp_row.dst), .i_exp_mw(exp_row.mw), .i_exp_bow(exp_row.bow),
        .i_exp_mr(exp_row.mr), .i_exp_pcw(exp_pcw), .i_exp_pcsrc(exp_pcsrc),
        .i_exp_alu4(exp_row.alu4), .i_exp_sh4(exp_row.sh4),
        .i_pc_write(pc_write), .i_mem_read(mem_read), .i_mem_write(mem_write),
        .i_byte_or_word(byte_or_word), .i_ir_write(ir_write), .i_reg_write(reg_write),
        .i_i_or_d(i_or_d), .i_mem_to_reg(mem_to_reg), .i_pc_src(pc_src),
        .i_alu_op(alu_op), .i_alu_src_a(alu_src_a), .i_alu_src_b(alu_src_b),
        .i_reg_dst(reg_dst), .i_sh_op(sh_op), .o_tests(tests), .o_errors(errors)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic add_row(input logic [5:0] op, input logic [5:0] fn, input logic br,
                           input int cyc, input int rw, input logic [2:0] m2r,
                           input logic [1:0] dst, input int mw, input logic bow,
                           input int mr, input int pcw, input logic [1:0] pcsrc,
                           input logic [2:0] alu4, input logic [2:0] sh4);
        row_t r;
        r = '{op, fn, br, cyc[3:0], rw[1:0], m2r, dst, mw[1:0], bow, mr[1:0],
              pcw[1:0], pcsrc, alu4, sh4};
        table_q.push_back(r);
    endtask

    task automatic wait_fetch();
        int n;
        n  = 0;
        ok = 1'b0;
        while (!ok && n < 20) begin
            @(posedge clk);
            ok = ir_write;
            n++;
        end
        if (!ok) begin
            $display("timeout, no instruction fetch within 20 cycles");
            $display("*** FAILED ***");
            $finish;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        reset   = 1'b1;
        instr   = '0;
        eq      = 1'b0;
        active  = 1'b0;
        test_id = 0;
        rnd     = 32'h83ff;
        exp_row = '{default: '0};
        exp_pcw = 2'd0;
        exp_pcsrc = 2'd0;
        //      op        fn      br cyc rw m2r          dst     mw bow mr pcw pcsrc   alu4 sh4
        add_row(OP_RTYPE, FN_ADD, 0, 5, 1, WB_ALU_OUT, DST_RD, 0, 0, 0, 0, PC_ALU, ALU_ADD, 0);
        add_row(OP_RTYPE, FN_SUB, 0, 5, 1, WB_ALU_OUT, DST_RD, 0, 0, 0, 0, PC_ALU, ALU_SUB, 0);
        add_row(OP_RTYPE, FN_AND, 0, 5, 1, WB_ALU_OUT, DST_RD, 0, 0, 0, 0, PC_ALU, ALU_AND, 0);
        add_row(OP_RTYPE, FN_SLL, 0, 5, 1, WB_SHIFT, DST_RD, 0, 0, 0, 0, PC_ALU, 0, SH_SLL);
        add_row(OP_RTYPE, FN_SRA, 0, 5, 1, WB_SHIFT, DST_RD, 0, 0, 0, 0, PC_ALU, 0, SH_SRA);
        add_row(OP_RTYPE, FN_SLT, 0, 4, 1, WB_LT, DST_RD, 0, 0, 0, 0, PC_ALU, ALU_SUB, 0);
        add_row(OP_RTYPE, FN_JR, 0, 4, 0, 0, DST_RT, 0, 0, 0, 1, PC_REG_A, 0, 0);
        add_row(OP_J, 0, 0, 4, 0, 0, DST_RT, 0, 0, 0, 1, PC_JUMP, 0, 0);
        add_row(OP_ADDI, 0, 0, 5, 1, WB_ALU_OUT, DST_RT, 0, 0, 0, 0, PC_ALU, ALU_ADD, 0);
        add_row(OP_BEQ, 0, 1, 4, 0, 0, DST_RT, 0, 0, 0, 1, PC_ALU_OUT, ALU_SUB, 0);
        add_row(OP_BNE, 0, 1, 4, 0, 0, DST_RT, 0, 0, 0, 1, PC_ALU_OUT, ALU_SUB, 0);
        add_row(OP_LUI, 0, 0, 4, 1, WB_LUI, DST_RT, 0, 0, 0, 0, PC_ALU, 0, 0);
        add_row(OP_LW, 0, 0, 6, 1, WB_MEM_WORD, DST_RT, 0, 0, 1, 0, PC_ALU, ALU_ADD, 0);
        add_row(OP_LB, 0, 0, 6, 1, WB_MEM_BYTE, DST_RT, 0, 0, 1, 0, PC_ALU, ALU_ADD, 0);
        add_row(OP_SW, 0, 0, 5, 0, 0, DST_RT, 1, 0, 0, 0, PC_ALU, ALU_ADD, 0);
        add_row(OP_SB, 0, 0, 6, 0, 0, DST_RT, 1, 1, 1, 0, PC_ALU, ALU_ADD, 0);
        add_row(6'h3f, 0, 0, 3, 0, 0, DST_RT, 0, 0, 0, 0, PC_ALU, 3'd7, 0); // bad opcode
        add_row(OP_RTYPE, 6'h3f, 0, 3, 0, 0, DST_RT, 0, 0, 0, 0, PC_ALU, 3'd7, 0); // bad funct
        expected_tests = 3 * table_q.size();

        repeat (3) @(posedge clk);
        #1 reset = 1'b0;

        // three passes so branches see both eq values
        for (int pass = 0; pass < 3; pass++) begin
            foreach (table_q[k]) begin
                wait_fetch();
                #1;
                exp_row = table_q[k];
                rnd     = xorshift(rnd);
                eq      = rnd[31];
                instr   = {exp_row.op, rnd[4:0], rnd[9:5], rnd[14:10], rnd[19:15], exp_row.fn};
                if (exp_row.op != OP_RTYPE) instr.i.imm = rnd[25:10];
                exp_pcw   = exp_row.br ? {1'b0, eq != exp_row.op[0]} : exp_row.pcw;
                exp_pcsrc = (exp_pcw == 0) ? PC_ALU : exp_row.pcsrc;
                test_id   = test_id + 1;
                active    = 1'b1;
            end
        end
        wait_fetch(); // checker closes the last test here
        #1 active = 1'b0;
        $display("tests run %0d of %0d, errors %0d", tests, expected_tests, errors);
        if (errors == 0 && tests == expected_tests) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
src/ctrl_pkg.sv
src/instr_decoder.sv
src/ctrl_sequencer.sv
src/ctrl_word_gen.sv
src/mips_ctrl_unit.sv
bench/ctrl_checker.sv
bench/tb_mips_ctrl_unit.sv

// File: Makefile
TOP := tb_mips_ctrl_unit

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f project.f --top-module $(TOP) -Mdir obj_dir -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -qF '*** PASSED ***' sim.log

lint:
	verilator --lint-only -Wall -f project.f --top-module mips_ctrl_unit

clean:
	rm -rf obj_dir sim.log
